/* design/opl_pkg.sv */
// Output port lookup package with datapath types, header fields and FSM states
package opl_pkg;

   ////////////////////////////////////////////////////////////
   // Datapath types
   ////////////////////////////////////////////////////////////

   typedef logic [63:0] data_t;       // One bus word
   typedef logic [7:0]  ctrl_t;       // Byte marker of a word
   typedef logic [47:0] mac_t;        // Ethernet address
   typedef logic [2:0]  port_num_t;   // Input port number
   typedef logic [15:0] port_mask_t;  // One-hot output ports in module header

   ////////////////////////////////////////////////////////////
   // Module header fields
   ////////////////////////////////////////////////////////////

   localparam int    DST_MASK_LO = 48;       // Destination mask in bits 63:48
   localparam int    SRC_PORT_LO = 16;       // Input port in bits 31:16
   localparam ctrl_t CTRL_HDR    = 8'hff;    // Marks the module header word

   // Flood address
   localparam mac_t  BCAST_MAC   = 48'hffff_ffff_ffff;

   // Parsed Ethernet header, 99 bits
   typedef struct packed {
      mac_t      dst_mac;
      mac_t      src_mac;
      port_num_t src_port;
   } eth_hdr_t;

   // Address table result
   typedef struct packed {
      logic      hit;    // Destination found
      port_num_t port;   // Port it was learned on
   } lookup_t;

   ////////////////////////////////////////////////////////////
   // State machines
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      READ_MODULE_HDR,
      READ_WORD_1,
      READ_WORD_2,
      WAIT_EOP
   } parse_state_t;

   typedef enum logic [1:0] {
      IDLE,        // Waiting for a decision
      SEND_HDR,    // Header word on read data
      SEND_BODY,
      DROP_BODY    // Popped without out_wr
   } ctrl_state_t;

endpackage

/* design/eth_parser.sv */
// Ethernet header parser that pulls the input port and both MACs off the 64-bit stream
`timescale 1ns/1ps

module eth_parser import opl_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   // Input stream
   input  data_t    in_data,
   input  ctrl_t    in_ctrl,
   input  logic     in_wr,
   // To address table and control
   output eth_hdr_t eth_hdr,
   output logic     eth_done
);

   parse_state_t state;
   parse_state_t state_next;

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      if (in_wr) begin
         case (state)
            READ_MODULE_HDR: begin
               if (in_ctrl == CTRL_HDR) begin
                  state_next = READ_WORD_1;
               end
            end
            READ_WORD_1: state_next = READ_WORD_2;
            READ_WORD_2: state_next = WAIT_EOP;
            WAIT_EOP: begin
               if (in_ctrl != '0) begin   // Last word of packet
                  state_next = READ_MODULE_HDR;
               end
            end
            default: state_next = READ_MODULE_HDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= READ_MODULE_HDR;
         eth_done <= 1'b0;
      end else begin
         state    <= state_next;
         eth_done <= in_wr && (state == READ_WORD_2);   // Pulse once word 2 is in
      end
   end

   ////////////////////////////////////////////////////////////
   // Field capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (in_wr) begin
         case (state)
            READ_MODULE_HDR: begin
               if (in_ctrl == CTRL_HDR) begin
                  eth_hdr.src_port <= in_data[SRC_PORT_LO +: $bits(port_num_t)];
               end
            end
            READ_WORD_1: begin
               eth_hdr.dst_mac        <= in_data[63:16];
               eth_hdr.src_mac[47:32] <= in_data[15:0];   // Upper source bytes
            end
            READ_WORD_2: begin
               eth_hdr.src_mac[31:0]  <= in_data[63:32];
            end
            default: ;
         endcase
      end
   end

   // Only one module header per packet
   a_hdr_placement: assert property (@(posedge clk) disable iff (reset)
      in_wr && in_ctrl == CTRL_HDR |-> state == READ_MODULE_HDR);

endmodule

/* design/mac_table.sv */
// Learning address table that looks up the destination and learns the source MAC
`timescale 1ns/1ps

module mac_table import opl_pkg::*; #(
   parameter int TABLE_DEPTH = 4
) (
   input  logic     clk,
   input  logic     reset,
   // From parser
   input  eth_hdr_t eth_hdr,
   input  logic     eth_done,
   // To control
   output lookup_t  lookup,
   output logic     lookup_done
);

   localparam int PTR_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;

   logic [TABLE_DEPTH-1:0] valid;
   mac_t                   mac  [TABLE_DEPTH];
   port_num_t              port [TABLE_DEPTH];

   logic [TABLE_DEPTH-1:0] dst_match;
   logic [TABLE_DEPTH-1:0] src_match;
   logic [PTR_W-1:0]       rr_ptr;      // Next entry to replace
   logic [PTR_W-1:0]       src_idx;
   logic [PTR_W-1:0]       learn_idx;
   logic                   src_known;
   lookup_t                lookup_next;

   ////////////////////////////////////////////////////////////
   // Parallel match
   ////////////////////////////////////////////////////////////

   always_comb begin
      lookup_next = '0;
      src_idx     = '0;
      for (int i = 0; i < TABLE_DEPTH; i++) begin
         dst_match[i] = valid[i] && (mac[i] == eth_hdr.dst_mac);
         src_match[i] = valid[i] && (mac[i] == eth_hdr.src_mac);
         if (dst_match[i]) begin
            lookup_next.hit  = 1'b1;
            lookup_next.port = port[i];
         end
         if (src_match[i]) begin
            src_idx = PTR_W'(i);
         end
      end
   end

   assign src_known = |src_match;
   assign learn_idx = src_known ? src_idx : rr_ptr;   // Update in place or replace

   ////////////////////////////////////////////////////////////
   // Control state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         valid       <= '0;       // Table starts empty
         rr_ptr      <= '0;
         lookup_done <= 1'b0;
      end else begin
         lookup_done <= eth_done;
         if (eth_done && !src_known) begin
            valid[rr_ptr] <= 1'b1;
            rr_ptr <= (rr_ptr == PTR_W'(TABLE_DEPTH - 1)) ? '0 : rr_ptr + 1'b1;
         end
      end
   end

   // Entries and result
   always_ff @(posedge clk) begin
      if (eth_done) begin
         lookup          <= lookup_next;   // Sees table before this learn
         mac[learn_idx]  <= eth_hdr.src_mac;
         port[learn_idx] <= eth_hdr.src_port;
      end
   end

   // Learning never leaves duplicate entries
   a_unique_match: assert property (@(posedge clk) disable iff (reset)
      eth_done |-> $onehot0(dst_match) && $onehot0(src_match));

endmodule

/* design/pkt_fifo.sv */
// Packet word FIFO with registered read, holds data and ctrl side by side
`timescale 1ns/1ps

module pkt_fifo import opl_pkg::*; #(
   parameter int FIFO_DEPTH = 32
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  wr_en,
   input  data_t wr_data,
   input  ctrl_t wr_ctrl,
   input  logic  rd_en,
   output data_t rd_data,
   output ctrl_t rd_ctrl,
   output logic  empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   data_t            mem_data [FIFO_DEPTH];
   ctrl_t            mem_ctrl [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;     // Words stored
   logic             full;

   assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign empty = (count == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(rd_en);
      end
   end

   // Storage, read data held between pops
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_data[wr_ptr] <= wr_data;
         mem_ctrl[wr_ptr] <= wr_ctrl;
      end
      if (rd_en) begin
         rd_data <= mem_data[rd_ptr];
         rd_ctrl <= mem_ctrl[rd_ptr];
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty);

endmodule

/* design/opl_ctrl.sv */
// Lookup control that forms the port mask, rewrites the header and drains or drops packets
`timescale 1ns/1ps

module opl_ctrl import opl_pkg::*; #(
   parameter int NUM_PORTS = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  ctrl_t    in_ctrl,
   input  logic     in_wr,
   input  eth_hdr_t eth_hdr,
   input  lookup_t  lookup,
   input  logic     lookup_done,
   // Packet FIFO
   output logic     rd_en,
   input  data_t    rd_data,
   input  ctrl_t    rd_ctrl,
   input  logic     empty,
   // Output stream
   output data_t    out_data,
   output ctrl_t    out_ctrl,
   output logic     out_wr
);

   localparam int         DQ_DEPTH  = 4;
   localparam port_mask_t ALL_PORTS = port_mask_t'((1 << NUM_PORTS) - 1);

   ctrl_state_t state, state_next;
   port_mask_t  new_mask, head_mask, cur_mask;
   logic        new_drop, head_drop, cur_drop;
   port_mask_t  dq_mask [DQ_DEPTH];   // Decisions waiting behind a draining packet
   logic        dq_drop [DQ_DEPTH];
   logic [1:0]  dq_wr_ptr, dq_rd_ptr;
   logic [2:0]  dq_count;
   logic        dq_push, dq_pop;
   logic        rd_vld;               // Word popped last cycle sits on rd_data
   logic        at_eop, dec_ready, start;
   logic [3:0]  pend_cnt;             // Headers in, decisions not yet out
   port_num_t   hdr_port;

   ////////////////////////////////////////////////////////////
   // Forwarding decision
   ////////////////////////////////////////////////////////////

   always_comb begin
      new_drop = 1'b0;
      if (eth_hdr.dst_mac == BCAST_MAC || !lookup.hit) begin
         new_mask = ALL_PORTS & ~(port_mask_t'(1) << eth_hdr.src_port);   // Flood
      end else begin
         new_mask = port_mask_t'(1) << lookup.port;
         new_drop = (lookup.port == eth_hdr.src_port);   // Would go back where it came from
      end
   end

   assign dec_ready = (dq_count != '0) || lookup_done;
   assign head_mask = (dq_count != '0) ? dq_mask[dq_rd_ptr] : new_mask;
   assign head_drop = (dq_count != '0) ? dq_drop[dq_rd_ptr] : new_drop;
   assign at_eop    = rd_vld && (rd_ctrl != '0);
   assign dq_push   = lookup_done && !(start && dq_count == '0);
   assign dq_pop    = start && (dq_count != '0);

   ////////////////////////////////////////////////////////////
   // Drain FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      start      = 1'b0;
      rd_en      = 1'b0;
      case (state)
         IDLE: start = dec_ready && !empty;
         SEND_HDR: begin
            rd_en      = !empty;   // First body word
            state_next = cur_drop ? DROP_BODY : SEND_BODY;
         end
         SEND_BODY, DROP_BODY: begin
            if (at_eop) begin
               start      = dec_ready && !empty;   // Next header back to back
               state_next = IDLE;
            end else begin
               rd_en = !empty;
            end
         end
         default: state_next = IDLE;
      endcase
      if (start) begin
         rd_en      = 1'b1;   // Pop the header
         state_next = SEND_HDR;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         rd_vld    <= 1'b0;
         dq_wr_ptr <= '0;
         dq_rd_ptr <= '0;
         dq_count  <= '0;
         pend_cnt  <= '0;
      end else begin
         state     <= state_next;
         rd_vld    <= rd_en;
         dq_wr_ptr <= dq_wr_ptr + 2'(dq_push);
         dq_rd_ptr <= dq_rd_ptr + 2'(dq_pop);
         dq_count  <= dq_count + 3'(dq_push) - 3'(dq_pop);
         pend_cnt  <= pend_cnt + 4'(in_wr && in_ctrl == CTRL_HDR) - 4'(lookup_done);
      end
   end

   always_ff @(posedge clk) begin
      if (dq_push) begin
         dq_mask[dq_wr_ptr] <= new_mask;
         dq_drop[dq_wr_ptr] <= new_drop;
      end
      if (start) begin
         cur_mask <= head_mask;
         cur_drop <= head_drop;
      end
   end

   // Output straight off the FIFO read register
   assign out_data = (state == SEND_HDR) ? {cur_mask, rd_data[DST_MASK_LO-1:0]} : rd_data;
   assign out_ctrl = rd_ctrl;
   assign out_wr   = rd_vld && ((state == SEND_HDR && !cur_drop) || state == SEND_BODY);
   assign hdr_port = rd_data[SRC_PORT_LO +: $bits(port_num_t)];

   a_hdr_mask: assert property (@(posedge clk) disable iff (reset)
      out_wr && state == SEND_HDR |->
         out_data[63:DST_MASK_LO] != '0 && !out_data[DST_MASK_LO + int'(hdr_port)]);

   // Every lookup belongs to a header that came in
   a_pending: assert property (@(posedge clk) disable iff (reset)
      lookup_done |-> pend_cnt != '0);

endmodule

/* design/opl_top.sv */
// Output port lookup stage top level joining parser, address table, packet FIFO and control
`timescale 1ns/1ps

module opl_top import opl_pkg::*; #(
   parameter int NUM_PORTS   = 4,
   parameter int TABLE_DEPTH = 4,
   parameter int FIFO_DEPTH  = 32
) (
   input  logic  clk,
   input  logic  reset,
   // Input stream
   input  data_t in_data,
   input  ctrl_t in_ctrl,
   input  logic  in_wr,
   // Output stream with rewritten header
   output data_t out_data,
   output ctrl_t out_ctrl,
   output logic  out_wr
);

   eth_hdr_t eth_hdr;
   logic     eth_done;
   lookup_t  lookup;
   logic     lookup_done;
   logic     rd_en;
   data_t    rd_data;
   ctrl_t    rd_ctrl;
   logic     empty;

   ////////////////////////////////////////////////////////////
   // Decision path
   ////////////////////////////////////////////////////////////

   eth_parser u_parser (
      .clk      (clk),
      .reset    (reset),
      .in_data  (in_data),
      .in_ctrl  (in_ctrl),
      .in_wr    (in_wr),
      .eth_hdr  (eth_hdr),
      .eth_done (eth_done)
   );

   mac_table #(.TABLE_DEPTH(TABLE_DEPTH)) u_table (
      .clk         (clk),
      .reset       (reset),
      .eth_hdr     (eth_hdr),
      .eth_done    (eth_done),
      .lookup      (lookup),
      .lookup_done (lookup_done)
   );

   ////////////////////////////////////////////////////////////
   // Packet path
   ////////////////////////////////////////////////////////////

   pkt_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (in_wr),     // Every input word buffered
      .wr_data (in_data),
      .wr_ctrl (in_ctrl),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .rd_ctrl (rd_ctrl),
      .empty   (empty)
   );

   opl_ctrl #(.NUM_PORTS(NUM_PORTS)) u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .in_ctrl     (in_ctrl),
      .in_wr       (in_wr),
      .eth_hdr     (eth_hdr),
      .lookup      (lookup),
      .lookup_done (lookup_done),
      .rd_en       (rd_en),
      .rd_data     (rd_data),
      .rd_ctrl     (rd_ctrl),
      .empty       (empty),
      .out_data    (out_data),
      .out_ctrl    (out_ctrl),
      .out_wr      (out_wr)
   );

endmodule

/* test/opl_tb_table.svh */
// Packet table with input port, MAC addresses, body length and expected forwarding
`ifndef OPL_TB_TABLE_SVH
`define OPL_TB_TABLE_SVH

localparam mac_t MAC_A = 48'h02_00_5e_00_10_0a;
localparam mac_t MAC_B = 48'h02_00_5e_00_20_0b;
localparam mac_t MAC_C = 48'h02_00_5e_00_30_0c;
localparam mac_t MAC_D = 48'h02_00_5e_00_40_0d;
localparam mac_t MAC_E = 48'h02_00_5e_00_50_0e;   // Never a source

// Columns: port, dst MAC, src MAC, body words, expected mask, drop, back to back
task automatic load_table();

   ////////////////////////////////////////////////////////////
   // Learning, unicast and broadcast
   ////////////////////////////////////////////////////////////

   add_row(3'd0, MAC_B,     MAC_A,     4'd8,  16'h000e, 1'b0, 1'b0);   // B unknown, flood
   add_row(3'd1, MAC_A,     MAC_B,     4'd9,  16'h0001, 1'b0, 1'b0);   // A on port 0
   add_row(3'd3, MAC_B,     BCAST_MAC, 4'd10, 16'h0002, 1'b0, 1'b0);   // Learns broadcast
   add_row(3'd1, BCAST_MAC, MAC_B,     4'd8,  16'h000d, 1'b0, 1'b0);   // Floods anyway

   // Drop, then two packets in flight
   add_row(3'd0, MAC_A,     MAC_A,     4'd11, 16'h0000, 1'b1, 1'b1);   // A on own port
   add_row(3'd2, MAC_B,     MAC_C,     4'd12, 16'h0002, 1'b0, 1'b1);
   add_row(3'd3, MAC_C,     BCAST_MAC, 4'd10, 16'h0004, 1'b0, 1'b0);

   ////////////////////////////////////////////////////////////
   // Eviction
   ////////////////////////////////////////////////////////////

   add_row(3'd3, MAC_E,     MAC_D,     4'd9,  16'h0007, 1'b0, 1'b0);   // Fifth source
   add_row(3'd1, MAC_A,     MAC_B,     4'd8,  16'h000d, 1'b0, 1'b0);   // A gone, floods
   add_row(3'd2, MAC_B,     MAC_C,     4'd9,  16'h0002, 1'b0, 1'b1);
   add_row(3'd1, MAC_C,     MAC_B,     4'd10, 16'h0004, 1'b0, 1'b0);
   add_row(3'd1, MAC_D,     MAC_B,     4'd12, 16'h0008, 1'b0, 1'b0);   // Newest entry
endtask

`endif

/* test/opl_tb.sv */
// Testbench for the output port lookup stage that drives table packets and checks the output
`timescale 1ns/1ps

module opl_tb import opl_pkg::*; ();

   localparam int DRAIN_TIMEOUT = 300;   // Cycles allowed for one drain

   typedef struct packed {
      port_num_t  port;
      mac_t       dst;
      mac_t       src;
      logic [3:0] len;    // Body words after module header
      port_mask_t mask;
      logic       drop;
      logic       b2b;    // Next packet follows with no gap
   } pkt_row_t;

   typedef struct packed {
      data_t data;
      ctrl_t ctrl;
   } word_t;

   logic  clk;
   logic  reset;
   data_t in_data;
   ctrl_t in_ctrl;
   logic  in_wr;
   data_t out_data;
   ctrl_t out_ctrl;
   logic  out_wr;

   pkt_row_t    rows[$];
   word_t       exp_words[$];   // Model of the output stream
   int          exp_pkts[$];    // Row index of each packet in flight including drops
   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          pkts_done;
   int          err_mark;       // Error count at current packet's header
   bit          timed_out;

   opl_top #(.NUM_PORTS(4), .TABLE_DEPTH(4), .FIFO_DEPTH(32)) DUT (
      .clk      (clk),
      .reset    (reset),
      .in_data  (in_data),
      .in_ctrl  (in_ctrl),
      .in_wr    (in_wr),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic add_row(input port_num_t port, input mac_t dst, input mac_t src,
                          input logic [3:0] len, input port_mask_t mask,
                          input logic drop, input logic b2b);
      pkt_row_t r;
      r.port = port;
      r.dst  = dst;
      r.src  = src;
      r.len  = len;
      r.mask = mask;
      r.drop = drop;
      r.b2b  = b2b;
      rows.push_back(r);
   endtask

   `include "opl_tb_table.svh"

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Random value in the low nbits of w
   task automatic rand_word(output data_t w, input int nbits);
      w = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr = lfsr_next(lfsr);
         w    = {w[62:0], lfsr[0]};   // One step per bit
      end
   endtask

   // Drive one word and copy it into the model unless dropped
   task automatic send_word(input data_t data, input ctrl_t ctrl, input data_t exp_data,
                            input logic skip);
      word_t w;
      @(negedge clk);
      in_data = data;
      in_ctrl = ctrl;
      in_wr   = 1'b1;
      if (!skip) begin
         w.data = exp_data;
         w.ctrl = ctrl;
         exp_words.push_back(w);
      end
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      in_wr = 1'b0;
   endtask

   task automatic send_packet(input int idx);
      pkt_row_t r;
      data_t    hdr;
      data_t    pay;
      data_t    word;
      ctrl_t    ctrl;
      r = rows[idx];
      rand_word(hdr, 32);
      rand_word(pay, 16);
      hdr = {hdr[31:0], 16'(r.port), pay[15:0]};   // Input port field
      exp_pkts.push_back(idx);
      send_word(hdr, CTRL_HDR, {r.mask, hdr[47:0]}, r.drop);
      for (int n = 1; n <= int'(r.len); n++) begin
         pay  = '0;
         ctrl = (n == int'(r.len)) ? ctrl_t'(8'h80 >> (idx % 8)) : 8'h00;   // Last word marker
         if (n == 2) begin
            rand_word(pay, 32);
         end else if (n > 2) begin
            rand_word(pay, 64);
         end
         if (n == 1) begin
            word = {r.dst, r.src[47:32]};
         end else if (n == 2) begin
            word = {r.src[31:0], pay[31:0]};
         end else begin
            word = pay;
         end
         send_word(word, ctrl, word, r.drop);
      end
   endtask

   task automatic wait_drain(output bit late);
      int cyc;
      cyc = 0;
      while (exp_words.size() != 0 && cyc < DRAIN_TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      late = (exp_words.size() != 0);
      if (late) begin
         $display("ERROR at %0t: timed out with %0d output words never sent",
                  $time, exp_words.size());
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Output monitor
   ////////////////////////////////////////////////////////////

   // Drops ahead of this header are confirmed by its arrival
   task automatic report_drops(input logic hdr_match);
      while (exp_pkts.size() != 0 && rows[exp_pkts[0]].drop) begin
         if (hdr_match) begin
            $display("Packet %0d from port %0d: dropped, nothing sent before next header",
                     exp_pkts[0], rows[exp_pkts[0]].port);
         end else begin
            $display("Packet %0d from port %0d: drop expected, next header out is wrong",
                     exp_pkts[0], rows[exp_pkts[0]].port);
         end
         pkts_done++;
         void'(exp_pkts.pop_front());
      end
   endtask

   task automatic end_packet();
      int idx;
      if (exp_pkts.size() == 0) begin
         $display("ERROR at %0t: packet end seen with no packet in flight", $time);
         errors++;
      end else begin
         idx = exp_pkts.pop_front();
         pkts_done++;
         $display("Packet %0d from port %0d: mask %h, %s", idx, rows[idx].port,
                  rows[idx].mask, (errors == err_mark) ? "ok" : "with errors");
      end
   endtask

   always @(negedge clk) begin : monitor
      word_t w;
      if (!reset && out_wr) begin
         if (exp_words.size() == 0) begin
            $display("ERROR at %0t: out_wr high with no word expected", $time);
            errors++;
         end else begin
            w = exp_words.pop_front();
            if (w.ctrl == CTRL_HDR) begin
               report_drops(out_data[47:0] === w.data[47:0]);
               err_mark = errors;
            end
            checks += 2;
            if (out_data !== w.data) begin
               $display("FAILED at %0t: out_data expected %h actual %h", $time, w.data, out_data);
               errors++;
            end
            if (out_ctrl !== w.ctrl) begin
               $display("FAILED at %0t: out_ctrl expected %h actual %h", $time, w.ctrl, out_ctrl);
               errors++;
            end
            if (w.ctrl != 8'h00 && w.ctrl != CTRL_HDR) begin
               end_packet();
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      reset     = 1'b1;
      in_data   = '0;
      in_ctrl   = '0;
      in_wr     = 1'b0;
      lfsr      = 32'h21d;
      errors    = 0;
      checks    = 0;
      pkts_done = 0;
      err_mark  = 0;
      timed_out = 1'b0;
      load_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < rows.size() && !timed_out; i++) begin
         send_packet(i);
         if (!rows[i].b2b || i == rows.size() - 1) begin
            idle_cycle();
            wait_drain(timed_out);   // Let the table settle before the next row
         end
      end
      $display("Summary: %0d of %0d packets done, %0d checks, %0d errors",
               pkts_done, rows.size(), checks, errors);
      if (errors == 0 && !timed_out && pkts_done == rows.size()) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* opl.f */
+incdir+test
design/opl_pkg.sv
design/eth_parser.sv
design/mac_table.sv
design/pkt_fifo.sv
design/opl_ctrl.sv
design/opl_top.sv
test/opl_tb.sv
